// ==== hw/decodePkg.sv ====
`default_nettype none

package decodePkg;

    localparam int InstWidth = 32;
    localparam int AddrWidth = 32;
    localparam int RegNumWidth = 5;
    localparam int ImmWidth = 26;
    localparam logic [RegNumWidth-1:0] LinkReg = 5'd1;   // bl return address

    localparam int MajorLsb = 26;   // bits 31..26
    localparam int MinorLsb = 22;   // bits 25..22
    localparam int SubLsb = 20;     // bits 21..20
    localparam int FuncLsb = 15;    // bits 19..15
    localparam int RkLsb = 10;
    localparam int RjLsb = 5;
    localparam int RdLsb = 0;

    typedef enum logic [2:0] {
        UnitNone = 3'd0,
        UnitAlu = 3'd1,
        UnitDiv = 3'd2,
        UnitMul = 3'd3,
        UnitLsu = 3'd5,
        UnitBru = 3'd7
    } unitClass_e;

    typedef enum logic [2:0] {ImmNone, Imm5, Imm12, Imm16, Imm20, Imm26} immKind_e;

    // per-unit operation index, 1-based
    typedef enum logic [4:0] {
        AluAddW = 5'd1, AluSubW, AluSlt, AluSltu, AluNor, AluAnd, AluOr, AluXor,
        AluSllW, AluSrlW, AluSraW,
        AluSlliW, AluSrliW, AluSraiW,
        AluSlti, AluSltui, AluAddiW, AluAndi, AluOri, AluXori,
        AluLu12iW, AluPcaddu12i
    } aluOp_e;
    typedef enum logic [4:0] {MulW = 5'd1, MulhW, MulhWu} mulOp_e;
    typedef enum logic [4:0] {DivW = 5'd1, ModW, DivWu, ModWu} divOp_e;
    typedef enum logic [4:0] {
        LsuLdB = 5'd1, LsuLdH, LsuLdW, LsuLdBu, LsuLdHu, LsuStB, LsuStH, LsuStW
    } lsuOp_e;
    typedef enum logic [4:0] {
        BruJirl = 5'd1, BruB, BruBl, BruBeq, BruBne, BruBlt, BruBge, BruBltu, BruBgeu
    } bruOp_e;

    typedef struct packed {
        unitClass_e unit;
        logic [4:0] index;
    } microOp_t;

    typedef struct packed {
        logic                 valid;
        logic [AddrWidth-1:0] addr;
        logic [InstWidth-1:0] inst;
        logic                 part;
        logic [AddrWidth-1:0] nextAddr;
    } fetchSlot_t;

    typedef struct packed {
        logic                   valid;
        microOp_t               opcode;
        logic                   immValid;
        logic [ImmWidth-1:0]    imm;
        logic                   src1Valid;
        logic [RegNumWidth-1:0] src1;
        logic                   src2Valid;
        logic [RegNumWidth-1:0] src2;
        logic                   writeValid;
        logic [RegNumWidth-1:0] writeReg;
        logic                   part;
        logic [AddrWidth-1:0]   nextAddr;
        logic [AddrWidth-1:0]   addr;
    } decodedUop_t;

endpackage

`default_nettype wire

// ==== hw/instMatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module instMatch (
    input  logic                            Clk,
    input  logic [decodePkg::InstWidth-1:0] inst,
    output decodePkg::microOp_t             opcode,
    output decodePkg::immKind_e             immKind
);
    import decodePkg::*;

    localparam logic [5:0] MajorArith = 6'd0;
    localparam logic [5:0] MajorLu12i = 6'd5;
    localparam logic [5:0] MajorPcaddu12i = 6'd7;
    localparam logic [5:0] MajorMem = 6'd10;
    localparam logic [5:0] MajorJirl = 6'd19;   // b .. bgeu follow in order
    localparam logic [3:0] MinorRegOps = 4'd0;
    localparam logic [3:0] MinorShift = 4'd1;
    localparam logic [1:0] SubRegReg = 2'd1;
    localparam logic [1:0] SubDiv = 2'd2;
    localparam logic [1:0] SubShift = 2'd0;

    // func codes of the reg/reg group, alu ops then the multiplies
    localparam logic [4:0] RegRegFunc [14] = '{
        5'd0, 5'd2, 5'd4, 5'd5, 5'd8, 5'd9, 5'd10, 5'd11, 5'd14, 5'd15, 5'd16,
        5'd24, 5'd25, 5'd26
    };
    localparam int MulFirst = 11;
    localparam logic [4:0] ShiftFunc [3] = '{5'd1, 5'd9, 5'd17};
    localparam logic [3:0] ImmAluMinor [6] = '{4'd8, 4'd9, 4'd10, 4'd13, 4'd14, 4'd15};
    // in lsu index order, loads first
    localparam logic [3:0] MemMinor [8] = '{4'd0, 4'd1, 4'd2, 4'd8, 4'd9, 4'd4, 4'd5, 4'd6};

    logic [5:0] major;
    logic [3:0] minor;
    logic [1:0] sub;
    logic [4:0] func;
    logic regOpsGroup;
    logic shiftGroup;
    logic [13:0] regRegHit;
    logic [3:0] divHit;
    logic [2:0] shiftHit;
    logic [5:0] immAluHit;
    logic lu12iHit;
    logic pcaddHit;
    logic [7:0] memHit;
    logic [8:0] branchHit;
    logic [45:0] matchLines;

    function automatic microOp_t makeOp(unitClass_e unit, int index);
        microOp_t op;
        op.unit = unit;
        op.index = 5'(index);
        return op;
    endfunction

    assign major = inst[MajorLsb +: 6];
    assign minor = inst[MinorLsb +: 4];
    assign sub = inst[SubLsb +: 2];
    assign func = inst[FuncLsb +: 5];

    assign regOpsGroup = major == MajorArith && minor == MinorRegOps;
    assign shiftGroup = major == MajorArith && minor == MinorShift && sub == SubShift;
    assign lu12iHit = major == MajorLu12i && !inst[25];
    assign pcaddHit = major == MajorPcaddu12i && !inst[25];

    always_comb begin
        for (int i = 0; i < 14; i++) begin
            regRegHit[i] = regOpsGroup && sub == SubRegReg && func == RegRegFunc[i];
        end
        for (int i = 0; i < 4; i++) begin
            divHit[i] = regOpsGroup && sub == SubDiv && func == 5'(i);
        end
        for (int i = 0; i < 3; i++) begin
            shiftHit[i] = shiftGroup && func == ShiftFunc[i];
        end
        for (int i = 0; i < 6; i++) begin
            immAluHit[i] = major == MajorArith && minor == ImmAluMinor[i];
        end
        for (int i = 0; i < 8; i++) begin
            memHit[i] = major == MajorMem && minor == MemMinor[i];
        end
        for (int i = 0; i < 9; i++) begin
            branchHit[i] = major == 6'(MajorJirl + i);
        end
    end

    assign matchLines = {branchHit, memHit, pcaddHit, lu12iHit, immAluHit, shiftHit,
                         divHit, regRegHit};

    // one-hot lines, so plain overwrite is safe
    always_comb begin
        opcode = '0;
        immKind = ImmNone;
        for (int i = 0; i < 14; i++) begin
            if (regRegHit[i]) begin
                opcode = (i < MulFirst) ? makeOp(UnitAlu, AluAddW + i)
                                        : makeOp(UnitMul, MulW + i - MulFirst);
            end
        end
        for (int i = 0; i < 4; i++) begin
            if (divHit[i]) opcode = makeOp(UnitDiv, DivW + i);
        end
        for (int i = 0; i < 3; i++) begin
            if (shiftHit[i]) begin
                opcode = makeOp(UnitAlu, AluSlliW + i);
                immKind = Imm5;
            end
        end
        for (int i = 0; i < 6; i++) begin
            if (immAluHit[i]) begin
                opcode = makeOp(UnitAlu, AluSlti + i);
                immKind = Imm12;
            end
        end
        if (lu12iHit || pcaddHit) begin
            opcode = makeOp(UnitAlu, lu12iHit ? AluLu12iW : AluPcaddu12i);
            immKind = Imm20;
        end
        for (int i = 0; i < 8; i++) begin
            if (memHit[i]) begin
                opcode = makeOp(UnitLsu, LsuLdB + i);
                immKind = Imm12;
            end
        end
        for (int i = 0; i < 9; i++) begin
            if (branchHit[i]) begin
                opcode = makeOp(UnitBru, BruJirl + i);
                immKind = (opcode.index == BruB || opcode.index == BruBl) ? Imm26 : Imm16;
            end
        end
    end

    // encodings of the kept set must never overlap
    matchOneHot: assert property (@(posedge Clk) $onehot0(matchLines));

endmodule

`default_nettype wire

// ==== hw/operandPick.sv ====
`timescale 1ns/1ps
`default_nettype none

module operandPick (
    input  decodePkg::fetchSlot_t  slot,
    input  decodePkg::microOp_t    opcode,
    input  decodePkg::immKind_e    immKind,
    output decodePkg::decodedUop_t uop
);
    import decodePkg::*;

    logic [RegNumWidth-1:0] rd;
    logic [RegNumWidth-1:0] rj;
    logic [RegNumWidth-1:0] rk;
    logic [ImmWidth-1:0] imm;
    logic legal;
    logic isAlu;
    logic isMul;
    logic isDiv;
    logic isLsu;
    logic isBru;
    logic aluRegReg;
    logic aluUpperImm;
    logic isLoad;
    logic isStore;
    logic isJirl;
    logic isBl;
    logic directJump;
    logic condBranch;

    assign rd = slot.inst[RdLsb +: RegNumWidth];
    assign rj = slot.inst[RjLsb +: RegNumWidth];
    assign rk = slot.inst[RkLsb +: RegNumWidth];

    assign legal = opcode != '0;   // zero opcode is illegal
    assign isAlu = opcode.unit == UnitAlu;
    assign isMul = opcode.unit == UnitMul;
    assign isDiv = opcode.unit == UnitDiv;
    assign isLsu = opcode.unit == UnitLsu;
    assign isBru = opcode.unit == UnitBru;

    assign aluRegReg = isAlu && opcode.index <= AluSraW;
    assign aluUpperImm = isAlu && (opcode.index == AluLu12iW || opcode.index == AluPcaddu12i);
    assign isLoad = isLsu && opcode.index < LsuStB;
    assign isStore = isLsu && opcode.index >= LsuStB;
    assign isJirl = isBru && opcode.index == BruJirl;
    assign isBl = isBru && opcode.index == BruBl;
    assign directJump = isBru && (opcode.index == BruB || opcode.index == BruBl);
    assign condBranch = isBru && opcode.index >= BruBeq;

    always_comb begin
        case (immKind)
            Imm5: imm = ImmWidth'(slot.inst[14:10]);
            Imm12: imm = ImmWidth'(slot.inst[21:10]);
            Imm16: imm = ImmWidth'(slot.inst[25:10]);
            Imm20: imm = ImmWidth'(slot.inst[24:5]);
            Imm26: imm = {slot.inst[9:0], slot.inst[25:10]};   // offs[25:16] on top
            default: imm = '0;
        endcase
    end

    always_comb begin
        uop.valid = slot.valid;
        uop.opcode = opcode;
        uop.immValid = legal && immKind != ImmNone;
        uop.imm = imm;
        uop.src1Valid = legal && !aluUpperImm && !directJump;
        uop.src1 = rj;
        uop.src2Valid = legal && (aluRegReg || isMul || isDiv || condBranch || isStore);
        uop.src2 = (condBranch || isStore) ? rd : rk;   // compare / store data sits in rd
        uop.writeValid = legal && (isAlu || isMul || isDiv || isLoad || isJirl || isBl);
        uop.writeReg = isBl ? LinkReg : rd;
        uop.part = slot.part;
        uop.nextAddr = slot.nextAddr;
        uop.addr = slot.addr;
    end

endmodule

`default_nettype wire

// ==== hw/decodeStageReg.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStageReg #(
    parameter int SlotCount = 2
) (
    input  logic                                   Clk,
    input  logic                                   reset,
    input  logic                                   decodeStop,
    input  logic                                   decodeFlush,
    input  decodePkg::decodedUop_t [SlotCount-1:0] nextUops,
    output decodePkg::decodedUop_t [SlotCount-1:0] decodedUops
);

    // flush beats stop, stop beats load
    always_ff @(posedge Clk) begin
        if (reset || decodeFlush) begin
            decodedUops <= '0;
        end else if (!decodeStop) begin
            for (int k = 0; k < SlotCount; k++) begin
                if (nextUops[k].valid) begin
                    decodedUops[k] <= nextUops[k];
                end else begin
                    decodedUops[k] <= '0;   // empty slot carries no stale fields
                end
            end
        end
    end

    for (genvar k = 0; k < SlotCount; k++) begin : gClearCheck
        clearedAfterFlush: assert property (
            @(posedge Clk) (reset || decodeFlush) |=> !decodedUops[k].valid
        );
    end

    heldOnStop: assert property (
        @(posedge Clk) (decodeStop && !decodeFlush && !reset)
            |=> decodedUops == $past(decodedUops)
    );

endmodule

`default_nettype wire

// ==== hw/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage #(
    parameter int SlotCount = 2
) (
    input  logic                                   Clk,
    input  logic                                   reset,
    input  logic                                   decodeStop,
    input  logic                                   decodeFlush,
    input  decodePkg::fetchSlot_t [SlotCount-1:0]  fetchSlots,
    output decodePkg::decodedUop_t [SlotCount-1:0] decodedUops
);
    import decodePkg::*;

    microOp_t [SlotCount-1:0] opcodes;
    immKind_e [SlotCount-1:0] immKinds;
    decodedUop_t [SlotCount-1:0] nextUops;

    // one matcher and picker per issue slot
    for (genvar k = 0; k < SlotCount; k++) begin : gSlot
        instMatch matcher (
            .Clk     (Clk),
            .inst    (fetchSlots[k].inst),
            .opcode  (opcodes[k]),
            .immKind (immKinds[k])
        );

        operandPick picker (
            .slot    (fetchSlots[k]),
            .opcode  (opcodes[k]),
            .immKind (immKinds[k]),
            .uop     (nextUops[k])
        );
    end

    decodeStageReg #(
        .SlotCount (SlotCount)
    ) stageReg (
        .Clk         (Clk),
        .reset       (reset),
        .decodeStop  (decodeStop),
        .decodeFlush (decodeFlush),
        .nextUops    (nextUops),
        .decodedUops (decodedUops)
    );

endmodule

`default_nettype wire

// ==== testbench/decodeModel.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// opcode byte is the unit class in bits 7..5 and the 1-based index below it
// 17-bit opcodes: alu reg/reg, mul, div, shift-immediate
localparam logic [16:0] Op17 [21] = '{
    17'h020, 17'h022, 17'h024, 17'h025, 17'h028, 17'h029, 17'h02a, 17'h02b,
    17'h02e, 17'h02f, 17'h030, 17'h038, 17'h039, 17'h03a,
    17'h040, 17'h041, 17'h042, 17'h043, 17'h081, 17'h089, 17'h091
};
localparam logic [7:0] Code17 [21] = '{
    8'h21, 8'h22, 8'h23, 8'h24, 8'h25, 8'h26, 8'h27, 8'h28,
    8'h29, 8'h2a, 8'h2b, 8'h61, 8'h62, 8'h63,
    8'h41, 8'h42, 8'h43, 8'h44, 8'h2c, 8'h2d, 8'h2e
};
// 10-bit opcodes: slti .. xori, then ld.b .. ld.hu, st.b .. st.w
localparam logic [9:0] Op10 [14] = '{
    10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e, 10'h00f,
    10'h0a0, 10'h0a1, 10'h0a2, 10'h0a8, 10'h0a9, 10'h0a4, 10'h0a5, 10'h0a6
};
localparam logic [7:0] Code10 [14] = '{
    8'h2f, 8'h30, 8'h31, 8'h32, 8'h33, 8'h34,
    8'ha1, 8'ha2, 8'ha3, 8'ha4, 8'ha5, 8'ha6, 8'ha7, 8'ha8
};

function automatic logic [31:0] lcgStep(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [7:0] lookupCode(logic [31:0] inst);
    for (int i = 0; i < 21; i++) begin
        if (inst[31:15] == Op17[i]) return Code17[i];
    end
    for (int i = 0; i < 14; i++) begin
        if (inst[31:22] == Op10[i]) return Code10[i];
    end
    if (inst[31:25] == 7'h0a) return 8'h35;   // lu12i.w
    if (inst[31:25] == 7'h0e) return 8'h36;   // pcaddu12i
    if (inst[31:26] >= 6'h13 && inst[31:26] <= 6'h1b) begin
        return {3'd7, 5'(inst[31:26] - 6'h12)};   // jirl .. bgeu
    end
    return 8'h00;
endfunction

function automatic decodedUop_t expectUop(fetchSlot_t slot);
    decodedUop_t u;
    logic [7:0] code;
    logic [2:0] unit;
    logic [4:0] idx;
    int immForm;
    logic legal;
    logic load;
    logic store;
    logic condBranch;
    logic bl;
    logic bOrBl;
    u = '0;
    if (!slot.valid) return u;   // empty slot, zero record
    code = lookupCode(slot.inst);
    unit = code[7:5];
    idx = code[4:0];
    legal = code != 8'h00;
    load = unit == 3'd5 && idx <= 5'd5;
    store = unit == 3'd5 && idx >= 5'd6;
    condBranch = unit == 3'd7 && idx >= 5'd4;
    bl = unit == 3'd7 && idx == 5'd3;
    bOrBl = unit == 3'd7 && (idx == 5'd2 || idx == 5'd3);
    if (unit == 3'd1 && idx >= 5'd12) begin
        immForm = (idx <= 5'd14) ? 5 : (idx <= 5'd20) ? 12 : 20;
    end else if (unit == 3'd5) begin
        immForm = 12;
    end else if (unit == 3'd7) begin
        immForm = bOrBl ? 26 : 16;
    end else begin
        immForm = 0;
    end
    case (immForm)
        5: u.imm = 26'(slot.inst[14:10]);
        12: u.imm = 26'(slot.inst[21:10]);
        16: u.imm = 26'(slot.inst[25:10]);
        20: u.imm = 26'(slot.inst[24:5]);
        26: u.imm = {slot.inst[9:0], slot.inst[25:10]};
        default: u.imm = '0;
    endcase
    u.valid = 1'b1;
    u.opcode = code;
    u.immValid = immForm != 0;
    u.src1 = slot.inst[9:5];
    u.src1Valid = legal && !(unit == 3'd1 && idx >= 5'd21) && !bOrBl;
    u.src2 = (condBranch || store) ? slot.inst[4:0] : slot.inst[14:10];
    u.src2Valid = (unit == 3'd1 && idx <= 5'd11) || unit == 3'd2 || unit == 3'd3
                  || condBranch || store;
    u.writeReg = bl ? 5'd1 : slot.inst[4:0];
    u.writeValid = unit == 3'd1 || unit == 3'd2 || unit == 3'd3 || load
                   || (unit == 3'd7 && idx == 5'd1) || bl;
    u.part = slot.part;
    u.nextAddr = slot.nextAddr;
    u.addr = slot.addr;
    return u;
endfunction

`endif

// ==== testbench/decodeStageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStageTb;
    import decodePkg::*;

    localparam int SlotCount = 2;
    localparam int DirectedCount = 46;
    localparam int RandomCycles = 300;

    // base encodings in opcode index order with register fields clear
    localparam logic [31:0] DirectedBase [DirectedCount] = '{
        32'h00100000, 32'h00110000, 32'h00120000, 32'h00128000, 32'h00140000, 32'h00148000,
        32'h00150000, 32'h00158000, 32'h00170000, 32'h00178000, 32'h00180000,
        32'h00408000, 32'h00448000, 32'h00488000,
        32'h02000000, 32'h02400000, 32'h02800000, 32'h03400000, 32'h03800000, 32'h03c00000,
        32'h14000000, 32'h1c000000, 32'h001c0000, 32'h001c8000, 32'h001d0000,
        32'h00200000, 32'h00208000, 32'h00210000, 32'h00218000,
        32'h28000000, 32'h28400000, 32'h28800000, 32'h2a000000, 32'h2a400000,
        32'h29000000, 32'h29400000, 32'h29800000,
        32'h4c000000, 32'h50000000, 32'h54000000, 32'h58000000, 32'h5c000000,
        32'h60000000, 32'h64000000, 32'h68000000, 32'h6c000000
    };

    logic Clk;
    logic reset;
    logic decodeStop;
    logic decodeFlush;
    fetchSlot_t [SlotCount-1:0] fetchSlots;
    decodedUop_t [SlotCount-1:0] decodedUops;
    decodedUop_t [SlotCount-1:0] expUops;
    logic [31:0] lcgState;
    logic checkOn;

    `include "decodeModel.svh"

    decodeStage #(
        .SlotCount (SlotCount)
    ) dut_i (
        .Clk         (Clk),
        .reset       (reset),
        .decodeStop  (decodeStop),
        .decodeFlush (decodeFlush),
        .fetchSlots  (fetchSlots),
        .decodedUops (decodedUops)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    always @(posedge Clk) begin
        if (reset || decodeFlush) begin
            expUops <= '0;
        end else if (!decodeStop) begin
            for (int k = 0; k < SlotCount; k++) begin
                expUops[k] <= expectUop(fetchSlots[k]);
            end
        end
    end

    outputMatch: assert property (@(posedge Clk) !checkOn || decodedUops == expUops)
        else begin
            $display("FAILED at time %0t: decodedUops = %h, expected %h", $time,
                     $sampled(decodedUops), $sampled(expUops));
            $display("tests failed");
            $fatal(1, "decoded record mismatch");
        end

    // operand fields of the kept encodings are free to vary
    function automatic logic [31:0] freeMask(logic [31:0] base);
        if (base[31:26] >= 6'h13) return 32'h03ff_ffff;
        if (base[31:26] == 6'h05 || base[31:26] == 6'h07) return 32'h01ff_ffff;
        if (base[31:26] == 6'h0a || base[25:22] >= 4'd8) return 32'h003f_ffff;
        return 32'h0000_7fff;
    endfunction

    function automatic logic anyValid();
        for (int k = 0; k < SlotCount; k++) begin
            if (decodedUops[k].valid) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic drawRandom(output logic [31:0] value);
        lcgState = lcgStep(lcgState);
        value = lcgState;
    endtask

    task automatic scrambleFields(input logic [31:0] base, output logic [31:0] word);
        logic [31:0] r;
        drawRandom(r);
        word = base | (r & freeMask(base));
    endtask

    task automatic fillSlot(input int k, input logic valid, input logic [31:0] inst);
        logic [31:0] r;
        drawRandom(r);
        fetchSlots[k].valid = valid;
        fetchSlots[k].inst = inst;
        fetchSlots[k].addr = {r[31:2], 2'b00};
        fetchSlots[k].nextAddr = {r[31:2], 2'b00} + 32'd4;
        fetchSlots[k].part = r[3];
    endtask

    // mix of known encodings and raw words
    task automatic driveRandomSlots(input logic allValid);
        logic [31:0] r;
        logic [31:0] w;
        for (int k = 0; k < SlotCount; k++) begin
            drawRandom(r);
            if (r[30]) begin
                scrambleFields(DirectedBase[int'(r[29:24]) % DirectedCount], w);
            end else begin
                drawRandom(w);
            end
            fillSlot(k, allValid || r[31], w);
        end
    endtask

    task automatic waitForEmpty(input int limit);
        int n;
        n = 0;
        while (anyValid()) begin
            if (n == limit) begin
                $display("timeout: decoded slots still valid after %0d cycles", limit);
                $display("tests failed");
                $fatal(1, "wait for empty stage timed out");
            end
            n++;
            @(negedge Clk);
        end
    endtask

    initial begin
        logic [31:0] w;
        int i;
        reset = 1'b1;
        decodeStop = 1'b0;
        decodeFlush = 1'b0;
        fetchSlots = '0;
        lcgState = 32'h75d882e1;
        checkOn = 1'b0;
        @(posedge Clk);
        @(negedge Clk);
        checkOn = 1'b1;
        repeat (9) @(negedge Clk);
        reset = 1'b0;
        @(negedge Clk);   // first edge out of reset sees empty slots
        waitForEmpty(2);

        // every kept instruction in both slots
        for (i = 0; i < DirectedCount; i++) begin
            scrambleFields(DirectedBase[i], w);
            fillSlot(0, 1'b1, w);
            scrambleFields(DirectedBase[(i + 23) % DirectedCount], w);
            fillSlot(1, 1'b1, w);
            @(negedge Clk);
        end

        for (i = 0; i < RandomCycles; i++) begin
            driveRandomSlots(1'b0);
            @(negedge Clk);
        end

        driveRandomSlots(1'b1);
        @(negedge Clk);
        decodeStop = 1'b1;
        repeat (6) begin
            driveRandomSlots(1'b1);   // dropped while stopped
            @(negedge Clk);
        end
        decodeStop = 1'b0;
        driveRandomSlots(1'b1);
        @(negedge Clk);

        decodeFlush = 1'b1;
        driveRandomSlots(1'b1);
        @(negedge Clk);
        decodeFlush = 1'b0;
        waitForEmpty(1);
        driveRandomSlots(1'b1);
        @(negedge Clk);
        decodeFlush = 1'b1;
        decodeStop = 1'b1;
        @(negedge Clk);
        decodeFlush = 1'b0;
        decodeStop = 1'b0;
        fetchSlots = '0;
        waitForEmpty(1);
        @(negedge Clk);

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+testbench
hw/decodePkg.sv
hw/instMatch.sv
hw/operandPick.sv
hw/decodeStageReg.sv
hw/decodeStage.sv
testbench/decodeStageTb.sv

// ==== run.sh ====
#!/bin/sh
# build the decode stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module decodeStageTb -f vlog.f -o decodeSim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/decodeSim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0
